//--- dsi_packet_assembler.f
+incdir+bench
verilog/dsi_pkg.sv
verilog/dsi_ifs.sv
verilog/frame_sequencer.sv
verilog/line_counter.sv
verilog/packet_writer.sv
verilog/lane_packer.sv
verilog/dsi_packet_assembler.sv
bench/tb_dsi_packet_assembler.sv

//--- Makefile
TOP := tb_dsi_packet_assembler

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f dsi_packet_assembler.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- bench/tb_dsi_tasks.svh
// ecc contribution of each header bit d0..d23 to p0..p5
localparam logic [7:0] ECC_SYNDROME [24] = '{
    8'h07, 8'h0B, 8'h0D, 8'h0E, 8'h13, 8'h15, 8'h16, 8'h19,
    8'h1A, 8'h1C, 8'h23, 8'h25, 8'h26, 8'h29, 8'h2A, 8'h2C,
    8'h31, 8'h32, 8'h34, 8'h38, 8'h1F, 8'h2F, 8'h37, 8'h3B
};

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
        errors++;
        $display("CHECK FAILED at %0d ns: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    errors++;
    $display("ERROR at %0d ns: %s", $time, msg);
endtask

function automatic logic [7:0] pix_byte(input int word, input int b);
    return 8'(word * 4 + b);                      // ramp over the byte position
endfunction

function automatic logic [31:0] pix_word(input int word);
    return {pix_byte(word, 3), pix_byte(word, 2), pix_byte(word, 1), pix_byte(word, 0)};
endfunction

function automatic logic [7:0] header_ecc(input logic [23:0] d);
    logic [7:0] e;
    e = 8'h00;
    for (int i = 0; i < 24; i++)
        if (d[i])
            e = e ^ ECC_SYNDROME[i];
    return e;
endfunction

// crc-16 lsb first over exp_q from first to its end
function automatic logic [15:0] payload_crc(input int first);
    logic [15:0] c;
    c = 16'hFFFF;
    for (int i = first; i < exp_q.size(); i++)
    begin
        c = c ^ {8'h00, exp_q[i]};
        for (int b = 0; b < 8; b++)
            c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
    end
    return c;
endfunction

function automatic int frame_bytes();
    return 4 + (LBLANK + 6) * (1 + VBP + VFP) + 4 * (VBP + VFP)
           + VACT * (4 + (HBP + 6) + (PPL * 3 + 6) + (HFP + 6));
endfunction

task automatic push_packet(input logic [7:0] id, input int n, input bit pixels);
    logic [15:0] field;
    logic [15:0] crc;
    int          start;
    field = (id == 8'h19 || id == 8'h3E) ? 16'(n) : 16'h0000; // short packets carry zero
    exp_q.push_back(id);
    exp_q.push_back(field[7:0]);
    exp_q.push_back(field[15:8]);
    exp_q.push_back(header_ecc({field, id}));
    if (field != 16'h0000 || id == 8'h19 || id == 8'h3E)
    begin
        start = exp_q.size();
        for (int j = 0; j < n; j++)
            exp_q.push_back(pixels ? pix_byte(ref_word + j / 4, j % 4) : 8'h55);
        if (pixels)
            ref_word += (n + 3) / 4;              // tail of the last word is dropped
        crc = payload_crc(start);
        exp_q.push_back(crc[7:0]);
        exp_q.push_back(crc[15:8]);
    end
endtask

task automatic build_frame();
    push_packet(8'h01, 0, 1'b0);                  // VSS line
    push_packet(8'h19, LBLANK, 1'b0);
    for (int i = 0; i < VBP; i++)
    begin
        push_packet(8'h21, 0, 1'b0);
        push_packet(8'h19, LBLANK, 1'b0);
    end
    for (int i = 0; i < VACT; i++)
    begin
        push_packet(8'h21, 0, 1'b0);
        push_packet(8'h19, HBP, 1'b0);
        push_packet(8'h3E, PPL * 3, 1'b1);
        push_packet(8'h19, HFP, 1'b0);
    end
    for (int i = 0; i < VFP; i++)
    begin
        push_packet(8'h21, 0, 1'b0);
        push_packet(8'h19, LBLANK, 1'b0);
    end
endtask

task automatic compare_stream(input string label);
    check_value({label, " byte count"}, 32'(exp_q.size()), 32'(got_q.size()));
    for (int i = 0; i < exp_q.size() && i < got_q.size(); i++)
        if (got_q[i] !== exp_q[i])
        begin
            check_value($sformatf("%s byte %0d", label, i), 32'(exp_q[i]), 32'(got_q[i]));
            break;                                // later bytes follow from the first slip
        end
endtask

task automatic run_frames(input string label, input logic [2:0] lanes, input int frames,
                          input bit lane_stall, input bit fifo_stall);
    int limit;
    int stop_at;
    int cycles;
    exp_q.delete();
    ref_word = 0;
    for (int f = 0; f < frames; f++)
        build_frame();
    stop_at = exp_q.size() - frame_bytes() / 2;   // middle of the last frame
    limit   = exp_q.size() * 8 + 400;
    cycles  = 0;
    @(negedge clk);
    got_q.delete();
    read_count       = 0;
    pix_index        = 0;
    lane_count       = lanes;
    full_random      = lane_stall;
    starve_random    = fifo_stall;
    streaming_enable = 1'b1;
    while (got_q.size() < stop_at && cycles < limit)
    begin
        @(negedge clk);
        cycles++;
    end
    streaming_enable = 1'b0;
    while (got_q.size() < exp_q.size() && cycles < limit)
    begin
        @(negedge clk);
        cycles++;
    end
    if (cycles >= limit)
        report_error({label, ": timed out waiting for the frame bytes on the lanes"});
    repeat (40) @(negedge clk);                   // room for any extra packet to show
    full_random   = 1'b0;
    starve_random = 1'b0;
    compare_stream(label);
    check_value({label, " pix_fifo_read count"}, 32'(frames * VACT * ((PPL * 3 + 3) / 4)),
                32'(read_count));
endtask

task automatic check_idle_outputs();
    @(posedge clk);
    check_value("lanes_write", 32'h0, 32'(lanes_write));
    check_value("pix_fifo_read", 32'h0, 32'(pix_fifo_read));
endtask

task automatic reset_quiet();
    rst_n = 1'b0;
    repeat (2) check_idle_outputs();
    @(negedge clk);
    rst_n = 1'b1;
    repeat (10) check_idle_outputs();
    check_value("bytes after reset", 32'h0, 32'(got_q.size()));
endtask

task automatic small_frame();
    run_frames("four lanes", 3'd4, 1, 1'b0, 1'b0);
endtask

task automatic lane_spread();
    run_frames("one lane", 3'd1, 1, 1'b0, 1'b0);
    run_frames("three lanes", 3'd3, 1, 1'b0, 1'b0);
endtask

task automatic back_pressure();
    run_frames("lanes_full stalls", 3'd3, 1, 1'b1, 1'b0);
endtask

task automatic pixel_starvation();
    run_frames("fifo starvation", 3'd4, 1, 1'b0, 1'b1);
endtask

task automatic streaming_stop();
    run_frames("streaming stop", 3'd4, 2, 1'b0, 1'b0);  // dropped inside the second frame
endtask

//--- bench/tb_dsi_packet_assembler.sv
module tb_dsi_packet_assembler;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_LANES    = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int VBP          = 1;
    localparam int VACT         = 2;
    localparam int VFP          = 1;
    localparam int PPL          = 2;              // pixels per line
    localparam int HBP          = 4;
    localparam int HFP          = 3;
    localparam int LBLANK       = 6;
    localparam int TOTAL_FRAMES = 7;              // frames over all stream tests

    logic                   clk;
    logic                   rst_n;
    logic                   streaming_enable;
    logic [2:0]             lane_count;
    logic [15:0]            line_blank_bytes;
    logic [15:0]            hbp_bytes;
    logic [15:0]            hfp_bytes;
    logic [15:0]            pixels_per_line;
    logic [15:0]            vbp_lines;
    logic [15:0]            vact_lines;
    logic [15:0]            vfp_lines;
    logic [31:0]            pix_fifo_data;
    logic                   pix_fifo_empty;
    logic                   pix_fifo_read;
    logic [NUM_LANES*8-1:0] lanes_data;
    logic [NUM_LANES-1:0]   lanes_write;
    logic                   lanes_full;

    logic [7:0] exp_q [$];                        // reference byte stream
    logic [7:0] got_q [$];                        // bytes collected from the lanes
    int         ref_word      = 0;
    int         pix_index     = 0;
    int         read_count    = 0;
    int         checks        = 0;
    int         errors        = 0;
    int         seed          = 32'h1121;
    bit         full_random   = 1'b0;
    bit         starve_random = 1'b0;
    bit         after_partial = 1'b0;

    `include "tb_dsi_tasks.svh"

    dsi_packet_assembler #(
        .NUM_LANES (NUM_LANES)
    ) dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .lane_count       (lane_count),
        .line_blank_bytes (line_blank_bytes),
        .hbp_bytes        (hbp_bytes),
        .hfp_bytes        (hfp_bytes),
        .pixels_per_line  (pixels_per_line),
        .vbp_lines        (vbp_lines),
        .vact_lines       (vact_lines),
        .vfp_lines        (vfp_lines),
        .pix_fifo_data    (pix_fifo_data),
        .pix_fifo_empty   (pix_fifo_empty),
        .pix_fifo_read    (pix_fifo_read),
        .lanes_data       (lanes_data),
        .lanes_write      (lanes_write),
        .lanes_full       (lanes_full)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // lane stalls, FIFO starvation and pixel ramp, all on the falling edge
    always @(negedge clk)
    begin
        lanes_full     = full_random && (($random(seed) & 3) == 0);
        pix_fifo_empty = starve_random && (($random(seed) & 1) == 1);
        pix_fifo_data  = pix_word(pix_index);
    end

    always @(posedge clk)
    begin : lane_monitor
        int n_wr;
        n_wr = $countones(lanes_write);
        if (!rst_n)
            after_partial = 1'b0;
        else
        begin
            if (pix_fifo_read)
            begin
                pix_index++;                      // FIFO pops on read
                read_count++;
            end
            if (lanes_full)
                check_value("lanes_write while lanes_full", 32'h0, 32'(lanes_write));
            if (n_wr != 0)
            begin
                check_value("lanes_write mask", 32'((1 << n_wr) - 1), 32'(lanes_write));
                if (n_wr > int'(lane_count))
                    report_error("more lanes written than lane_count allows");
                if (after_partial)
                    report_error("lane write in the cycle after a partial beat");
                for (int i = 0; i < n_wr; i++)
                    got_q.push_back(lanes_data[i*8 +: 8]); // lane order is stream order
            end
            after_partial = (n_wr != 0) && (n_wr < int'(lane_count)); // packer now empty
        end
    end

    initial
    begin : watchdog
        longint budget_ns;
        budget_ns = longint'(TOTAL_FRAMES * frame_bytes() * 8 + 8 * 450) * CLK_PERIOD * 2;
        #(budget_ns);
        $display("watchdog expired after %0d ns, the run did not complete", budget_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        rst_n            = 1'b0;
        streaming_enable = 1'b0;
        lane_count       = 3'd4;
        lanes_full       = 1'b0;
        pix_fifo_empty   = 1'b0;
        pix_fifo_data    = pix_word(0);
        line_blank_bytes = 16'(LBLANK);
        hbp_bytes        = 16'(HBP);
        hfp_bytes        = 16'(HFP);
        pixels_per_line  = 16'(PPL);
        vbp_lines        = 16'(VBP);
        vact_lines       = 16'(VACT);
        vfp_lines        = 16'(VFP);
        reset_quiet();
        small_frame();
        lane_spread();
        back_pressure();
        pixel_starvation();
        streaming_stop();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end
endmodule

//--- verilog/dsi_packet_assembler.sv
module dsi_packet_assembler #(
    parameter int NUM_LANES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   streaming_enable,
    input  logic [2:0]             lane_count,
    input  dsi_pkg::count_t        line_blank_bytes,
    input  dsi_pkg::count_t        hbp_bytes,
    input  dsi_pkg::count_t        hfp_bytes,
    input  dsi_pkg::count_t        pixels_per_line,
    input  dsi_pkg::count_t        vbp_lines,
    input  dsi_pkg::count_t        vact_lines,
    input  dsi_pkg::count_t        vfp_lines,
    input  logic [31:0]            pix_fifo_data,
    input  logic                   pix_fifo_empty,
    output logic                   pix_fifo_read,
    output logic [NUM_LANES*8-1:0] lanes_data,
    output logic [NUM_LANES-1:0]   lanes_write,
    input  logic                   lanes_full
);
    logic       phase_start;
    logic       line_done;
    logic       last_line;
    logic [1:0] phase;

    header_if      hdr ();
    byte_stream_if stream ();

    frame_sequencer u_seq (
        .clk              (clk),
        .rst_n            (rst_n),
        .streaming_enable (streaming_enable),
        .line_blank_bytes (line_blank_bytes),
        .hbp_bytes        (hbp_bytes),
        .hfp_bytes        (hfp_bytes),
        .pixels_per_line  (pixels_per_line),
        .last_line        (last_line),
        .phase_start      (phase_start),
        .line_done        (line_done),
        .phase            (phase),
        .hdr              (hdr.sequencer)
    );

    line_counter u_lines (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase_start (phase_start),
        .line_done   (line_done),
        .vbp_lines   (vbp_lines),
        .vact_lines  (vact_lines),
        .vfp_lines   (vfp_lines),
        .phase       (phase),
        .last_line   (last_line)
    );

    packet_writer u_writer (
        .clk            (clk),
        .rst_n          (rst_n),
        .pix_fifo_data  (pix_fifo_data),
        .pix_fifo_empty (pix_fifo_empty),
        .pix_fifo_read  (pix_fifo_read),
        .hdr            (hdr.writer),
        .stream         (stream.source)
    );

    lane_packer #(
        .NUM_LANES (NUM_LANES)
    ) u_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .lane_count  (lane_count),
        .lanes_full  (lanes_full),
        .lanes_data  (lanes_data),
        .lanes_write (lanes_write),
        .stream      (stream.sink)
    );
endmodule

//--- verilog/lane_packer.sv
module lane_packer #(
    parameter int NUM_LANES = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [2:0]             lane_count,
    input  logic                   lanes_full,
    output logic [NUM_LANES*8-1:0] lanes_data,
    output logic [NUM_LANES-1:0]   lanes_write,
    byte_stream_if.sink            stream
);
    logic [63:0] buf_q;                           // byte 0 is next on the wire
    logic [63:0] buf_nx;
    logic [3:0]  cnt;                             // bytes held, 0 to 8
    logic [3:0]  beat_n;
    logic [3:0]  sent;
    logic [3:0]  rem;
    logic        beat;
    logic        take_in;

    assign stream.ready = (cnt <= 4'd4);          // room for a full word
    assign take_in      = stream.valid && stream.ready;
    assign beat_n       = (cnt < {1'b0, lane_count}) ? cnt : {1'b0, lane_count};
    // partial beat only when nothing is arriving
    assign beat         = !lanes_full && cnt != 4'd0
                          && (cnt >= {1'b0, lane_count} || !stream.valid);
    assign sent         = beat ? beat_n : 4'd0;
    assign rem          = cnt - sent;

    always_comb
    begin
        int idx;
        buf_nx = '0;
        for (int j = 0; j < 8; j++)
        begin
            idx = j - int'(rem);
            if (j < int'(rem))
                buf_nx[j*8 +: 8] = buf_q[(j + int'(sent))*8 % 64 +: 8];
            else if (take_in && idx < int'(stream.nbytes))
                buf_nx[j*8 +: 8] = stream.data[idx*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= 4'd0;
        else
            cnt <= rem + (take_in ? {1'b0, stream.nbytes} : 4'd0);
    end

    always_ff @(posedge clk)
    begin
        buf_q <= buf_nx;
    end

    assign lanes_data = buf_q[NUM_LANES*8-1:0];

    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
            lanes_write[i] = beat && (i < int'(beat_n));
    end

    no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        lanes_full |-> lanes_write == '0);
endmodule

//--- verilog/packet_writer.sv
module packet_writer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] pix_fifo_data,
    input  logic        pix_fifo_empty,
    output logic        pix_fifo_read,
    header_if.writer    hdr,
    byte_stream_if.source stream
);
    import dsi_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_HDR, W_PAY, W_CRC} wstate_t;

    wstate_t     wstate;
    dsi_header_t hdr_q;
    dsi_header_t hdr_nx;
    count_t      remaining;                       // payload bytes still to send
    logic        is_long;
    logic        is_pix;
    logic        in_long;
    logic [15:0] crc;
    logic        accept;

    function automatic logic [7:0] ecc24(input logic [23:0] d);
        logic [23:0] mask [6];
        logic [7:0]  p;
        mask = '{24'hF12CB7, 24'hF2555B, 24'h749A6D, 24'hB8E38E, 24'hDF03F0, 24'hEFFC00};
        p = 8'h00;                                // p7 and p6 stay zero
        for (int k = 0; k < 6; k++)
            p[k] = ^(d & mask[k]);
        return p;
    endfunction

    // reflected 0x1021, lsb first
    function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [31:0] d,
                                             input logic [2:0] n);
        logic [15:0] r;
        logic        fb;
        r = c;
        for (int b = 0; b < 32; b++)
        begin
            if (b < n * 8)
            begin
                fb = r[0] ^ d[b];
                r  = r >> 1;
                if (fb)
                    r = r ^ 16'h8408;
            end
        end
        return r;
    endfunction

    assign hdr.take = (wstate == W_IDLE) && hdr.valid;
    assign in_long  = (hdr.data_id == DT_BLANKING) || (hdr.data_id == DT_PIXEL_RGB24);
    assign accept   = stream.valid && stream.ready;

    always_comb
    begin
        if (in_long)
            hdr_nx.long_view = '{ecc: 8'h00, wc: hdr.field, data_id: hdr.data_id};
        else
            hdr_nx.short_view = '{ecc: 8'h00, data1: hdr.field[15:8],
                                  data0: hdr.field[7:0], data_id: hdr.data_id};
        hdr_nx.long_view.ecc = ecc24(hdr_nx[23:0]);
    end

    always_comb
    begin
        stream.valid  = 1'b0;
        stream.data   = hdr_q;
        stream.nbytes = 3'd4;
        case (wstate)
            W_HDR:   stream.valid = 1'b1;
            W_PAY:
            begin
                stream.valid  = !(is_pix && pix_fifo_empty); // stall on empty FIFO
                stream.data   = is_pix ? pix_fifo_data : {4{BLANK_BYTE}};
                stream.nbytes = (remaining >= 16'd4) ? 3'd4 : remaining[2:0];
            end
            W_CRC:
            begin
                stream.valid  = 1'b1;
                stream.data   = {16'h0000, crc};  // low byte first
                stream.nbytes = 3'd2;
            end
            default: ;
        endcase
    end

    assign pix_fifo_read = (wstate == W_PAY) && is_pix && accept;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wstate <= W_IDLE;
        else
            case (wstate)
                W_IDLE: if (hdr.take) wstate <= W_HDR;
                W_HDR:  if (accept) wstate <= !is_long ? W_IDLE :
                                              (remaining == '0) ? W_CRC : W_PAY;
                W_PAY:  if (accept && remaining <= 16'd4) wstate <= W_CRC;
                W_CRC:  if (accept) wstate <= W_IDLE;
                default: wstate <= W_IDLE;
            endcase
    end

    always_ff @(posedge clk)
    begin
        if (hdr.take)
        begin
            hdr_q     <= hdr_nx;
            is_long   <= in_long;
            is_pix    <= (hdr.data_id == DT_PIXEL_RGB24);
            remaining <= in_long ? hdr.field : '0;
            crc       <= 16'hFFFF;                // seed per packet
        end
        else if (wstate == W_PAY && accept)
        begin
            remaining <= remaining - count_t'(stream.nbytes);
            crc       <= crc_step(crc, stream.data, stream.nbytes);
        end
    end

    no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pix_fifo_read |-> !pix_fifo_empty);
endmodule

//--- verilog/line_counter.sv
module line_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            phase_start,
    input  logic            line_done,
    input  dsi_pkg::count_t vbp_lines,
    input  dsi_pkg::count_t vact_lines,
    input  dsi_pkg::count_t vfp_lines,
    input  logic [1:0]      phase,
    output logic            last_line
);
    import dsi_pkg::*;

    count_t remaining;                            // lines left, current included
    count_t load_val;

    always_comb
    begin
        case (phase)
            2'd0:    load_val = vbp_lines;
            2'd1:    load_val = vact_lines;
            default: load_val = vfp_lines;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            remaining <= '0;
        else if (phase_start)
            remaining <= load_val;
        else if (line_done && remaining != '0)
            remaining <= remaining - 16'd1;
    end

    // empty phase reports last right away so the sequencer skips it
    assign last_line = phase_start ? (load_val == '0) : (remaining <= 16'd1);
endmodule

//--- verilog/frame_sequencer.sv
module frame_sequencer (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            streaming_enable,
    input  dsi_pkg::count_t line_blank_bytes,
    input  dsi_pkg::count_t hbp_bytes,
    input  dsi_pkg::count_t hfp_bytes,
    input  dsi_pkg::count_t pixels_per_line,
    input  logic            last_line,
    output logic            phase_start,
    output logic            line_done,
    output logic [1:0]      phase,
    header_if.sequencer     hdr
);
    import dsi_pkg::*;

    localparam logic [1:0] PH_VBP  = 2'd0;
    localparam logic [1:0] PH_VACT = 2'd1;
    localparam logic [1:0] PH_VFP  = 2'd2;

    typedef enum logic [2:0] {
        IDLE, VSS, VSS_BLANK, HSS, SYNC_BLANK, HBP, RGB, HFP
    } state_t;

    state_t     state, state_nx;
    logic [1:0] phase_nx;
    logic       start_nx;
    logic       line_end;                         // current line may close here

    assign hdr.valid = (state != IDLE) && !phase_start; // counter loads first
    assign line_end  = (hdr.take && (state == SYNC_BLANK || state == HFP))
                       || (state == HSS && phase_start);
    assign line_done = hdr.take && (state == SYNC_BLANK || state == HFP);

    always_comb
    begin
        state_nx = state;
        phase_nx = phase;
        start_nx = 1'b0;
        case (state)
            IDLE:       if (streaming_enable) state_nx = VSS;
            VSS:        if (hdr.take) state_nx = VSS_BLANK;
            VSS_BLANK:
            begin
                if (hdr.take)
                begin
                    state_nx = HSS;
                    phase_nx = PH_VBP;
                    start_nx = 1'b1;
                end
            end
            HSS:        if (hdr.take) state_nx = (phase == PH_VACT) ? HBP : SYNC_BLANK;
            HBP:        if (hdr.take) state_nx = RGB;
            RGB:        if (hdr.take) state_nx = HFP;
            default:    ;
        endcase
        if (line_end)
        begin
            if (!last_line)
                state_nx = HSS;                   // more lines in this phase
            else if (phase == PH_VFP)
                state_nx = streaming_enable ? VSS : IDLE; // end of frame
            else
            begin
                state_nx = HSS;
                phase_nx = phase + 2'd1;
                start_nx = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= IDLE;
            phase       <= PH_VBP;
            phase_start <= 1'b0;
        end
        else
        begin
            state       <= state_nx;
            phase       <= phase_nx;
            phase_start <= start_nx;
        end
    end

    always_comb
    begin
        hdr.data_id = DT_HSS;
        hdr.field   = '0;
        case (state)
            VSS:                   hdr.data_id = DT_VSS;
            VSS_BLANK, SYNC_BLANK:
            begin
                hdr.data_id = DT_BLANKING;
                hdr.field   = line_blank_bytes;
            end
            HBP:
            begin
                hdr.data_id = DT_BLANKING;
                hdr.field   = hbp_bytes;
            end
            RGB:
            begin
                hdr.data_id = DT_PIXEL_RGB24;
                hdr.field   = count_t'(pixels_per_line * 3); // three bytes per pixel
            end
            HFP:
            begin
                hdr.data_id = DT_BLANKING;
                hdr.field   = hfp_bytes;
            end
            default:               ;
        endcase
    end

    hdr_held: assert property (@(posedge clk) disable iff (!rst_n)
        hdr.valid && !hdr.take |=> hdr.valid);
endmodule

//--- verilog/dsi_ifs.sv
interface header_if;
    logic              valid;                     // level, held until take
    logic              take;                      // one-cycle pulse from writer
    logic [7:0]        data_id;
    dsi_pkg::count_t   field;                     // word count, zero for short

    modport sequencer (
        output valid,
        output data_id,
        output field,
        input  take
    );

    modport writer (
        input  valid,
        input  data_id,
        input  field,
        output take
    );
endinterface

interface byte_stream_if;
    logic        valid;
    logic        ready;
    logic [31:0] data;                            // byte 0 goes first
    logic [2:0]  nbytes;                          // 1 to 4

    modport source (
        output valid,
        output data,
        output nbytes,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  nbytes,
        output ready
    );
endinterface

//--- verilog/dsi_pkg.sv
package dsi_pkg;

    typedef logic [15:0] count_t;                 // line, byte and word counts

    // data identifiers, virtual channel 0
    localparam logic [7:0] DT_VSS         = 8'h01;
    localparam logic [7:0] DT_HSS         = 8'h21;
    localparam logic [7:0] DT_BLANKING    = 8'h19;
    localparam logic [7:0] DT_PIXEL_RGB24 = 8'h3E;

    localparam logic [7:0] BLANK_BYTE     = 8'h55; // blanking payload fill

    typedef struct packed {
        logic [7:0] ecc;
        count_t     wc;                           // payload byte count
        logic [7:0] data_id;
    } long_hdr_t;

    typedef struct packed {
        logic [7:0] ecc;
        logic [7:0] data1;
        logic [7:0] data0;
        logic [7:0] data_id;
    } short_hdr_t;

    // one header word, two decodings
    typedef union packed {
        long_hdr_t  long_view;
        short_hdr_t short_view;
    } dsi_header_t;

endpackage
